// File: build.f
+incdir+include
verilog/conv_geom_pkg.sv
verilog/conv_data_pkg.sv
verilog/line_window.sv
verilog/weight_bank.sv
verilog/kernel_channel_pe.sv
verilog/psum_router.sv
verilog/line_conv_engine.sv
tests/tb_line_conv_engine.sv

// File: include/tb_conv_checks.svh
`ifndef TB_CONV_CHECKS_SVH
`define TB_CONV_CHECKS_SVH

////////////////////////////////////////////////////////////
// Compare bookkeeping

// Totals over the whole run
int error_count = 0;
int check_count = 0;

// Full psum word compare, lists each kernel on a miss
task automatic check_psum(
    input string                      name,
    input conv_data_pkg::kernel_psum_s got,
    input conv_data_pkg::kernel_psum_s exp
);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        for (int k = 0; k < $size(got.kn); k++) begin
            if (got.kn[k] !== exp.kn[k]) begin
                $display("  kernel %0d got %0d expected %0d", k, got.kn[k], exp.kn[k]);
            end
        end
    end
endtask

// Single control bit compare
task automatic check_bit(
    input string name,
    input logic  got,
    input logic  exp
);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

`endif

// File: tests/tb_line_conv_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_line_conv_engine;
    import conv_geom_pkg::*;
    import conv_data_pkg::*;

    // One line of stimulus
    typedef struct packed {
        line_width_t width;
        logic [31:0] wseed;
        logic [7:0]  gaps;
        logic        reload;
    } line_case_s;

    // Expected output word and the cycle it is due in
    typedef struct packed {
        kernel_psum_s psum;
        logic         last;
        logic [31:0]  due;
    } expect_s;

    logic         clk;
    logic         rst;
    pixel_vec_s   i_data;
    logic         i_data_vld;
    weight_tap_s  i_weight;
    logic         i_weight_vld;
    conf_reg_t    i_conf_inputshape;
    kernel_psum_s o_psum;
    logic         o_psum_vld;
    logic         o_psum_end;
    logic         o_weight_ready;

    line_case_s   cases [6];
    weight_tap_s  model_taps [NUM_TAP];
    expect_s      exp_q [$];
    logic [31:0]  pix_state;
    logic [31:0]  cycle;
    logic         monitor_on;
    logic         timed_out;

    `include "tb_conv_checks.svh"

    line_conv_engine UUT (
        .clk               (clk),
        .rst               (rst),
        .i_data            (i_data),
        .i_data_vld        (i_data_vld),
        .i_weight          (i_weight),
        .i_weight_vld      (i_weight_vld),
        .i_conf_inputshape (i_conf_inputshape),
        .o_psum            (o_psum),
        .o_psum_vld        (o_psum_vld),
        .o_psum_end        (o_psum_end),
        .o_weight_ready    (o_weight_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Rising edge count, used to time each result
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Sum over taps and channels, pos[0] the oldest pixel
    function automatic kernel_psum_s expected_psum(input window_s win);
        kernel_psum_s r;
        int           acc;
        for (int k = 0; k < NUM_KERNEL; k++) begin
            acc = 0;
            for (int t = 0; t < NUM_TAP; t++) begin
                for (int c = 0; c < NUM_CHANNEL; c++) begin
                    acc += int'(win.pos[t].ch[c]) * int'(model_taps[t].w[k][c]);
                end
            end
            r.kn[k] = psum_t'(acc);
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Output monitor

    always @(negedge clk) begin : result_monitor
        expect_s head;
        logic    due;
        if (monitor_on) begin
            due = (exp_q.size() > 0) && (exp_q[0].due == cycle);
            check_bit("o_psum_vld", o_psum_vld, due);
            if (due) begin
                head = exp_q.pop_front();
                check_psum("o_psum", o_psum, head.psum);
                check_bit("o_psum_end", o_psum_end, head.last);
            end else begin
                check_bit("o_psum_end", o_psum_end, 1'b0);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks

    // Three strobes, ready must stay low until the last one
    task automatic load_weights(input logic [31:0] seed);
        logic [31:0] st;
        weight_tap_s tap;
        st = seed;
        for (int t = 0; t < NUM_TAP; t++) begin
            @(negedge clk);
            if (t > 0) begin
                check_bit("o_weight_ready", o_weight_ready, 1'b0);
            end
            for (int q = 0; q < 3; q++) begin
                st = xorshift32(st);
                tap[32*q +: 32] = st;
            end
            model_taps[t] = tap;
            i_weight      = tap;
            i_weight_vld  = 1'b1;
        end
        @(negedge clk);
        i_weight_vld = 1'b0;
        check_bit("o_weight_ready", o_weight_ready, 1'b1);
    endtask

    task automatic send_line(input line_case_s lc);
        window_s win;
        expect_s e;
        for (int j = 0; j < lc.width; j++) begin
            // Idle cycle with junk on the data bus
            if (lc.gaps[j % 8]) begin
                pix_state = xorshift32(pix_state);
                @(negedge clk);
                i_data     = pixel_vec_s'(pix_state[23:0]);
                i_data_vld = 1'b0;
            end
            pix_state = xorshift32(pix_state);
            @(negedge clk);
            i_data     = pixel_vec_s'(pix_state[23:0]);
            i_data_vld = 1'b1;
            win.pos    = {i_data, win.pos[NUM_TAP-1:1]};
            if (j >= NUM_TAP - 1) begin
                e.psum = expected_psum(win);
                e.last = (j == lc.width - 1);
                e.due  = cycle + 3;
                exp_q.push_back(e);
            end
        end
        @(negedge clk);
        i_data_vld = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d expected results never appeared", exp_q.size());
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        rst               = 1'b1;
        i_data            = '0;
        i_data_vld        = 1'b0;
        i_weight          = '0;
        i_weight_vld      = 1'b0;
        i_conf_inputshape = '0;
        cycle             = '0;
        monitor_on        = 1'b0;
        timed_out         = 1'b0;
        pix_state         = 32'd977;

        // Width, weight seed, gap mask, reload
        cases[0] = '{8'd5,   32'h0000_1234, 8'h00,       1'b1};
        cases[1] = '{8'd3,   32'h9e37_79b9, 8'h00,       1'b1};
        cases[2] = '{8'd12,  32'h0bad_cafe, 8'b10100101, 1'b0};
        cases[3] = '{8'd4,   32'h0000_0777, 8'hff,       1'b1};
        cases[4] = '{8'd255, 32'h1357_9bdf, 8'h00,       1'b1};
        cases[5] = '{8'd9,   32'h2468_ace0, 8'b01001001, 1'b0};

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst        = 1'b0;
        monitor_on = 1'b1;
        check_bit("o_weight_ready", o_weight_ready, 1'b0);

        // Pixels before any weights must be ignored
        i_conf_inputshape = conf_reg_t'(cases[0].width);
        for (int n = 0; n < 4; n++) begin
            pix_state = xorshift32(pix_state);
            @(negedge clk);
            i_data     = pixel_vec_s'(pix_state[23:0]);
            i_data_vld = 1'b1;
        end
        @(negedge clk);
        i_data_vld = 1'b0;

        for (int i = 0; i < 6 && !timed_out; i++) begin
            i_conf_inputshape = conf_reg_t'(cases[i].width);
            if (cases[i].reload) begin
                load_weights(cases[i].wseed);
            end
            send_line(cases[i]);
            wait_drain();
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/line_conv_engine.sv
`timescale 1ns/1ps
`default_nettype none

module line_conv_engine (
    input  wire                               clk,
    input  wire                               rst,
    input  wire  conv_data_pkg::pixel_vec_s   i_data,
    input  wire                               i_data_vld,
    input  wire  conv_data_pkg::weight_tap_s  i_weight,
    input  wire                               i_weight_vld,
    input  wire  conv_geom_pkg::conf_reg_t    i_conf_inputshape,
    output conv_data_pkg::kernel_psum_s       o_psum,
    output logic                              o_psum_vld,
    output logic                              o_psum_end,
    output logic                              o_weight_ready
);
    import conv_geom_pkg::*;
    import conv_data_pkg::*;

    weight_tap_s  [NUM_TAP-1:0] taps;
    logic                       weight_ready;
    window_s                    window;
    logic                       window_vld;
    logic                       window_last;
    kernel_psum_s [NUM_TAP-1:0] pe_psum;
    logic         [NUM_TAP-1:0] pe_vld;
    logic                       pe_last;
    line_result_s               result;

    weight_bank u_weight_bank (
        .clk          (clk),
        .rst          (rst),
        .i_weight     (i_weight),
        .i_weight_vld (i_weight_vld),
        .o_taps       (taps),
        .o_ready      (weight_ready)
    );

    line_window u_line_window (
        .clk            (clk),
        .rst            (rst),
        .i_data         (i_data),
        .i_data_vld     (i_data_vld),
        .i_weight_ready (weight_ready),
        .i_line_width   (i_conf_inputshape[LINE_WIDTH_MSB:0]),
        .o_window       (window),
        .o_window_vld   (window_vld),
        .o_last         (window_last)
    );

    ////////////////////////////////////////////////////////////
    // PE array, tap t against window position t

    for (genvar t = 0; t < NUM_TAP; t++) begin : g_pe
        if (t == 0) begin : g_lead
            // Lead PE carries the end of line mark
            kernel_channel_pe u_pe (
                .clk     (clk),
                .rst     (rst),
                .i_pixel (window.pos[t]),
                .i_tap   (taps[t]),
                .i_vld   (window_vld),
                .i_last  (window_last),
                .o_psum  (pe_psum[t]),
                .o_vld   (pe_vld[t]),
                .o_last  (pe_last)
            );
        end else begin : g_follow
            kernel_channel_pe u_pe (
                .clk     (clk),
                .rst     (rst),
                .i_pixel (window.pos[t]),
                .i_tap   (taps[t]),
                .i_vld   (window_vld),
                .i_last  (1'b0),
                .o_psum  (pe_psum[t]),
                .o_vld   (pe_vld[t]),
                .o_last  ()
            );
        end
    end

    psum_router u_psum_router (
        .clk      (clk),
        .rst      (rst),
        .i_psum   (pe_psum),
        .i_vld    (&pe_vld),
        .i_last   (pe_last),
        .o_result (result),
        .o_vld    (o_psum_vld)
    );

    assign o_psum         = result.psum;
    assign o_psum_end     = result.last;
    assign o_weight_ready = weight_ready;

endmodule

`default_nettype wire

// File: verilog/psum_router.sv
`timescale 1ns/1ps
`default_nettype none

module psum_router (
    input  wire                                                        clk,
    input  wire                                                        rst,
    input  wire  conv_data_pkg::kernel_psum_s [conv_geom_pkg::NUM_TAP-1:0] i_psum,
    input  wire                                                        i_vld,
    input  wire                                                        i_last,
    output conv_data_pkg::line_result_s                                o_result,
    output logic                                                       o_vld
);
    import conv_data_pkg::*;

    kernel_psum_s sum;
    kernel_psum_s psum_q;
    logic         last_q;

    ////////////////////////////////////////////////////////////
    // Position reduction

    // Adds the three window positions per kernel, modulo 2^16
    always_comb begin
        sum = '0;
        for (int p = 0; p < $size(i_psum); p++) begin
            for (int k = 0; k < $size(sum.kn); k++) begin
                sum.kn[k] = sum.kn[k] + i_psum[p].kn[k];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output registers

    always_ff @(posedge clk) begin
        if (i_vld) begin
            psum_q <= sum;
        end
    end

    // Strobe and end mark last exactly one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            o_vld  <= 1'b0;
            last_q <= 1'b0;
        end else begin
            o_vld  <= i_vld;
            last_q <= i_vld & i_last;
        end
    end

    assign o_result = '{last: last_q, psum: psum_q};

endmodule

`default_nettype wire

// File: verilog/kernel_channel_pe.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_channel_pe (
    input  wire                                clk,
    input  wire                                rst,
    input  wire  conv_data_pkg::pixel_vec_s    i_pixel,
    input  wire  conv_data_pkg::weight_tap_s   i_tap,
    input  wire                                i_vld,
    input  wire                                i_last,
    output conv_data_pkg::kernel_psum_s        o_psum,
    output logic                               o_vld,
    output logic                               o_last
);
    import conv_data_pkg::*;

    kernel_psum_s dot;

    ////////////////////////////////////////////////////////////
    // Channel dot product per kernel

    // Operands widened first so every product and sum wraps at 16 bits
    always_comb begin
        dot = '0;
        for (int k = 0; k < $size(dot.kn); k++) begin
            for (int c = 0; c < $size(i_pixel.ch); c++) begin
                dot.kn[k] = dot.kn[k]
                          + psum_t'(i_pixel.ch[c]) * psum_t'(i_tap.w[k][c]);
            end
        end
    end

    // Result only moves on a valid window
    always_ff @(posedge clk) begin
        if (i_vld) begin
            o_psum <= dot;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_vld  <= 1'b0;
            o_last <= 1'b0;
        end else begin
            o_vld  <= i_vld;
            o_last <= i_vld & i_last;
        end
    end

endmodule

`default_nettype wire

// File: verilog/weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

module weight_bank (
    input  wire                                                       clk,
    input  wire                                                       rst,
    input  wire  conv_data_pkg::weight_tap_s                          i_weight,
    input  wire                                                       i_weight_vld,
    output conv_data_pkg::weight_tap_s [conv_geom_pkg::NUM_TAP-1:0]   o_taps,
    output logic                                                      o_ready
);
    import conv_geom_pkg::*;
    import conv_data_pkg::*;

    weight_state_e             state;
    tap_idx_t                  tap_idx;
    logic                      last_tap;
    weight_tap_s [NUM_TAP-1:0] taps;

    assign last_tap = (tap_idx == tap_idx_t'(NUM_TAP - 1));

    ////////////////////////////////////////////////////////////
    // Load FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= LOAD;
            tap_idx <= '0;
        end else if (i_weight_vld) begin
            if (state == READY) begin
                // Reload, this strobe already fills slot 0
                state   <= LOAD;
                tap_idx <= tap_idx_t'(1);
            end else if (last_tap) begin
                state   <= READY;
                tap_idx <= '0;
            end else begin
                tap_idx <= tap_idx + 1'b1;
            end
        end
    end

    // Tap storage, index is back at 0 whenever the bank is ready
    always_ff @(posedge clk) begin
        if (i_weight_vld) begin
            taps[tap_idx] <= i_weight;
        end
    end

    assign o_taps  = taps;
    assign o_ready = (state == READY);

endmodule

`default_nettype wire

// File: verilog/line_window.sv
`timescale 1ns/1ps
`default_nettype none

module line_window (
    input  wire                                clk,
    input  wire                                rst,
    input  wire  conv_data_pkg::pixel_vec_s    i_data,
    input  wire                                i_data_vld,
    input  wire                                i_weight_ready,
    input  wire  conv_geom_pkg::line_width_t   i_line_width,
    output conv_data_pkg::window_s             o_window,
    output logic                               o_window_vld,
    output logic                               o_last
);
    import conv_geom_pkg::*;
    import conv_data_pkg::*;

    logic        sample;
    line_width_t col;
    logic        col_end;
    logic        in_line;

    // Pixels are only taken once a full weight row is present
    assign sample = i_data_vld & i_weight_ready;

    ////////////////////////////////////////////////////////////
    // Column decode

    assign col_end = (col == line_width_t'(i_line_width - 1'b1));

    // Window is complete once the two older taps hold pixels of this line
    assign in_line = (col >= line_width_t'(NUM_TAP - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            col <= '0;
        end else if (sample) begin
            if (col_end) begin
                col <= '0;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Window shift register

    // Newest pixel enters at the top, pos[0] drops out
    always_ff @(posedge clk) begin
        if (sample) begin
            for (int p = 0; p < NUM_TAP - 1; p++) begin
                o_window.pos[p] <= o_window.pos[p+1];
            end
            o_window.pos[NUM_TAP-1] <= i_data;
        end
    end

    // One strobe per window that lies fully inside the line
    always_ff @(posedge clk) begin
        if (rst) begin
            o_window_vld <= 1'b0;
            o_last       <= 1'b0;
        end else begin
            o_window_vld <= sample & in_line;
            o_last       <= sample & in_line & col_end;
        end
    end

endmodule

`default_nettype wire

// File: verilog/conv_data_pkg.sv
`default_nettype none

package conv_data_pkg;

    ////////////////////////////////////////////////////////////
    // Value widths

    localparam int BIT_WIDTH = 8;

    // Products and sums are kept to twice the pixel width and wrap
    localparam int PSUM_WIDTH = 2 * BIT_WIDTH;

    typedef logic [BIT_WIDTH-1:0]  pixel_t;
    typedef logic [BIT_WIDTH-1:0]  weight_t;
    typedef logic [PSUM_WIDTH-1:0] psum_t;

    ////////////////////////////////////////////////////////////
    // Bundles

    // One pixel, channel 0 in the low bits
    typedef struct packed {
        pixel_t [conv_geom_pkg::NUM_CHANNEL-1:0] ch;
    } pixel_vec_s;

    // One weight tap, kernel 0 in the low bits
    // and channel 0 lowest within each kernel
    typedef struct packed {
        weight_t [conv_geom_pkg::NUM_KERNEL-1:0][conv_geom_pkg::NUM_CHANNEL-1:0] w;
    } weight_tap_s;

    // Three consecutive pixels of a line, pos[0] is the oldest
    typedef struct packed {
        pixel_vec_s [conv_geom_pkg::NUM_TAP-1:0] pos;
    } window_s;

    // One partial sum per kernel
    typedef struct packed {
        psum_t [conv_geom_pkg::NUM_KERNEL-1:0] kn;
    } kernel_psum_s;

    // Engine output word with its end of line mark
    typedef struct packed {
        logic         last;
        kernel_psum_s psum;
    } line_result_s;

endpackage

`default_nettype wire

// File: verilog/conv_geom_pkg.sv
`default_nettype none

package conv_geom_pkg;

    ////////////////////////////////////////////////////////////
    // Array geometry

    // Channels per pixel and kernels per weight tap
    localparam int NUM_CHANNEL = 3;
    localparam int NUM_KERNEL  = 4;

    // Taps in one weight row, one kernel-channel PE per tap
    localparam int NUM_TAP = 3;

    ////////////////////////////////////////////////////////////
    // Configuration registers

    localparam int REG_WIDTH = 32;

    // Line width field sits in the low byte of the input shape register
    localparam int LINE_WIDTH_MSB = 7;

    typedef logic [REG_WIDTH-1:0] conf_reg_t;

    // Line width, also used for the column position inside a line
    typedef logic [LINE_WIDTH_MSB:0] line_width_t;

    // Slot index into the weight bank
    typedef logic [$clog2(NUM_TAP)-1:0] tap_idx_t;

    ////////////////////////////////////////////////////////////
    // Weight bank FSM

    // LOAD while taps are still being written, READY once the row is full
    typedef enum logic {
        LOAD,
        READY
    } weight_state_e;

endpackage

`default_nettype wire
